// File: flist.f
+incdir+.
ext_mem_pkg.sv
store_pair_queue.sv
store_write_arbiter.sv
ext_mem_array.sv
mem_error_monitor.sv
ext_mem_top.sv
tb_ext_mem.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the external memory testbench with Verilator, runs it and scans the log
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module tb_ext_mem \
  -Mdir obj_dir -o sim_ext_mem
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_ext_mem > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "sim failed" "$LOG"; then
  echo "Testbench reported failure"
  exit 1
fi

echo "Run finished without failure"
exit 0

// File: tb_ext_mem.sv
// Self-checking testbench for the external memory model; compile with the RTL from flist.f
`timescale 1ns/100ps
`include "ext_mem_config.svh"

module tb_ext_mem
  import ext_mem_pkg::*;
();

  localparam int WAIT_LIMIT = 50;

  typedef enum logic [1:0] {OP_STORE, OP_LOAD, OP_CHECK} op_kind_e;

  // One table row whose expected field is the ld_done tag on check rows
  typedef struct packed {
    op_kind_e  kind;
    logic      port;
    mem_addr_t addr;
    mem_data_t data;
    req_tag_t  tag;
    mem_data_t expected;
  } op_row_t;

  logic                                  clk = 1'b0;
  logic                                  rst_n;
  logic     [`EXT_MEM_LD_PORTS-1:0]      ld_req_valid;
  ld_req_t  [`EXT_MEM_LD_PORTS-1:0]      ld_req;
  logic     [`EXT_MEM_LD_PORTS-1:0]      ld_req_ready;
  logic     [`EXT_MEM_LD_PORTS-1:0]      ld_rsp_valid;
  mem_rsp_t [`EXT_MEM_LD_PORTS-1:0]      ld_rsp;
  logic     [`EXT_MEM_LD_PORTS-1:0]      ld_rsp_ready;
  logic                                  ld_done_valid;
  mem_rsp_t                              ld_done;
  logic                                  ld_done_ready;
  logic     [`EXT_MEM_ST_PORTS-1:0]      st_addr_valid;
  st_addr_t [`EXT_MEM_ST_PORTS-1:0]      st_addr;
  logic     [`EXT_MEM_ST_PORTS-1:0]      st_addr_ready;
  logic     [`EXT_MEM_ST_PORTS-1:0]      st_data_valid;
  st_data_t [`EXT_MEM_ST_PORTS-1:0]      st_data;
  logic     [`EXT_MEM_ST_PORTS-1:0]      st_data_ready;
  logic                                  st_done_valid;
  mem_rsp_t                              st_done;
  logic                                  st_done_ready = 1'b0;
  logic                                  error_valid;
  err_code_t                             error_code;

  op_row_t   ops [$];
  mem_data_t ref_mem [`EXT_MEM_DEPTH];
  integer    seed;
  int        mismatches;
  int        timeouts;
  int        bp_mode;
  int        done_cnt = 0;
  req_tag_t  last_done_tag;

  ext_mem_top uut (.*);

  always #10 clk = ~clk;

  // Ready for st_done is held low in mode 0 and high in mode 1 and is random otherwise
  always @(posedge clk) begin
    case (bp_mode)
      0:       st_done_ready <= 1'b0;
      1:       st_done_ready <= 1'b1;
      default: st_done_ready <= 1'($random(seed));
    endcase
  end

  // Store-done beats are counted mid-cycle where everything is settled
  always @(negedge clk) begin
    if (rst_n && st_done_valid && st_done_ready) begin
      done_cnt = done_cnt + 1;
      last_done_tag = st_done.tag;
      check_value("store done data", st_done.data, 32'd0);
    end
    if (rst_n) begin
      check_value("extra write grants", 32'($countones(uut.grant) > 1), 32'd0);
    end
  end

  // ----------------------------------------------------------
  // Check and wait helpers
  // ----------------------------------------------------------
  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      mismatches++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, expected);
    end
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("Timeout at %0t: gave up waiting for %s", $time, what);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst_n         <= 1'b0;
    ld_req_valid  <= '0;
    st_addr_valid <= '0;
    st_data_valid <= '0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
  endtask

  task automatic send_addr(input int p, input req_tag_t tag, input mem_addr_t addr);
    int n;
    n = 0;
    @(posedge clk);
    st_addr_valid[p] <= 1'b1;
    st_addr[p]       <= {tag, addr};
    @(negedge clk);
    while (!st_addr_ready[p] && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!st_addr_ready[p]) report_timeout("store address ready");
    @(posedge clk);
    st_addr_valid[p] <= 1'b0;
  endtask

  task automatic send_data(input int p, input req_tag_t tag, input mem_data_t data);
    int n;
    n = 0;
    @(posedge clk);
    st_data_valid[p] <= 1'b1;
    st_data[p]       <= {tag, data};
    @(negedge clk);
    while (!st_data_ready[p] && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!st_data_ready[p]) report_timeout("store data ready");
    @(posedge clk);
    st_data_valid[p] <= 1'b0;
  endtask

  task automatic store_on_port(input int p, input mem_addr_t addr, input mem_data_t data,
                               input req_tag_t tag);
    ref_mem[addr] = data;
    fork
      send_addr(p, tag, addr);
      send_data(p, tag, data);
    join
  endtask

  task automatic wait_done(input int target);
    int n;
    n = 0;
    @(posedge clk);
    while (done_cnt < target && n < WAIT_LIMIT * 4) begin
      @(posedge clk);
      n++;
    end
    if (done_cnt < target) report_timeout("store done beats");
  endtask

  task automatic wait_error(input int limit);
    int n;
    n = 0;
    @(negedge clk);
    while (!error_valid && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (!error_valid) report_timeout("error_valid");
  endtask

  // Zero latency load checked in the same cycle
  task automatic load_one(input int p, input mem_addr_t addr, input req_tag_t tag);
    @(posedge clk);
    ld_req_valid[p] <= 1'b1;
    ld_req[p]       <= {tag, addr};
    @(negedge clk);
    check_value("load ready", 32'(ld_req_ready[p]), 32'd1);
    check_value("load valid", 32'(ld_rsp_valid[p]), 32'd1);
    check_value("load data", ld_rsp[p].data, ref_mem[addr]);
    check_value("load tag", 32'(ld_rsp[p].tag), 32'(tag));
    check_value("load done tag", 32'(ld_done.tag), 32'(tag));
    check_value("load done data", ld_done.data, 32'd0);
    @(posedge clk);
    ld_req_valid[p] <= 1'b0;
  endtask

  // Both load ports at once with port 1 reading the next word under the other tag
  task automatic load_both(input mem_addr_t addr, input req_tag_t tag, input req_tag_t done_tag);
    mem_addr_t addr1;
    addr1 = mem_addr_t'(addr + 8'd1);
    @(posedge clk);
    ld_req_valid <= 2'b11;
    ld_req[0]    <= {tag, addr};
    ld_req[1]    <= {req_tag_t'(tag ^ 2'd1), addr1};
    @(negedge clk);
    check_value("dual load data 0", ld_rsp[0].data, ref_mem[addr]);
    check_value("dual load data 1", ld_rsp[1].data, ref_mem[addr1]);
    check_value("dual load tag 0", 32'(ld_rsp[0].tag), 32'(tag));
    check_value("dual load tag 1", 32'(ld_rsp[1].tag), 32'(tag ^ 2'd1));
    check_value("dual load done", 32'({ld_done_valid, ld_done.tag}), 32'({1'b1, done_tag}));
    @(posedge clk);
    ld_req_valid <= 2'b00;
  endtask

  // ----------------------------------------------------------
  // Operation table
  // ----------------------------------------------------------
  task automatic build_table();
    // Kind, port, address, data, tag, expected
    ops.push_back(op_row_t'{OP_STORE, 1'b0, 8'h10, 32'hA5A5_0010, 2'd0, 32'd0});
    ops.push_back(op_row_t'{OP_STORE, 1'b1, 8'h11, 32'h5A5A_0011, 2'd1, 32'd0});
    ops.push_back(op_row_t'{OP_STORE, 1'b0, 8'h20, 32'h1234_0020, 2'd1, 32'd0});
    ops.push_back(op_row_t'{OP_STORE, 1'b1, 8'h21, 32'h8765_0021, 2'd0, 32'd0});
    ops.push_back(op_row_t'{OP_LOAD,  1'b0, 8'h11, 32'd0,        2'd1, 32'd0});
    ops.push_back(op_row_t'{OP_LOAD,  1'b1, 8'h10, 32'd0,        2'd0, 32'd0});
    ops.push_back(op_row_t'{OP_CHECK, 1'b0, 8'h10, 32'd0,        2'd0, 32'd1});
    ops.push_back(op_row_t'{OP_CHECK, 1'b0, 8'h20, 32'd0,        2'd1, 32'd0});
  endtask

  task automatic run_table();
    int base;
    foreach (ops[i]) begin
      case (ops[i].kind)
        OP_STORE: begin
          base = done_cnt;
          store_on_port(int'(ops[i].port), ops[i].addr, ops[i].data, ops[i].tag);
          wait_done(base + 1);
          check_value("store done tag", 32'(last_done_tag), 32'(ops[i].tag));
        end
        OP_LOAD:  load_one(int'(ops[i].port), ops[i].addr, ops[i].tag);
        default:  load_both(ops[i].addr, ops[i].tag, req_tag_t'(ops[i].expected));
      endcase
    end
  endtask

  // ----------------------------------------------------------
  // Directed sequences
  // ----------------------------------------------------------
  task automatic pair_order_test();
    int base;
    base = done_cnt;
    ref_mem[8'h50] = 32'hCAFE_0050;
    send_addr(0, 2'd1, 8'h50);
    repeat (4) @(posedge clk);
    check_value("done before data", 32'(done_cnt), 32'(base));
    send_data(0, 2'd0, 32'hCAFE_0050);
    wait_done(base + 1);
    repeat (4) @(posedge clk);
    check_value("beats for address first", 32'(done_cnt), 32'(base + 1));
    check_value("address first tag", 32'(last_done_tag), 32'd1);
    ref_mem[8'h51] = 32'hBEEF_0051;
    send_data(1, 2'd1, 32'hBEEF_0051);
    repeat (4) @(posedge clk);
    send_addr(1, 2'd0, 8'h51);
    wait_done(base + 2);
    repeat (4) @(posedge clk);
    check_value("beats for data first", 32'(done_cnt), 32'(base + 2));
    check_value("data first tag", 32'(last_done_tag), 32'd0);
    load_one(0, 8'h50, 2'd0);
    load_one(1, 8'h51, 2'd1);
  endtask

  task automatic concurrent_test();
    mem_data_t vals0 [6];
    mem_data_t vals1 [6];
    int        base;
    base = done_cnt;
    for (int i = 0; i < 6; i++) begin
      vals0[i] = $random(seed);
      vals1[i] = $random(seed);
    end
    bp_mode = 2;
    fork
      for (int i = 0; i < 6; i++) begin
        store_on_port(0, mem_addr_t'(8'h40 + i), vals0[i], req_tag_t'(i % 2));
      end
      for (int j = 0; j < 6; j++) begin
        store_on_port(1, mem_addr_t'(8'h80 + j), vals1[j], req_tag_t'((j + 1) % 2));
      end
    join
    bp_mode = 1;
    wait_done(base + 12);
    repeat (4) @(posedge clk);
    check_value("beats for concurrent stores", 32'(done_cnt), 32'(base + 12));
    for (int i = 0; i < 6; i++) begin
      load_one(i % 2, mem_addr_t'(8'h40 + i), 2'd0);
      load_one((i + 1) % 2, mem_addr_t'(8'h80 + i), 2'd1);
    end
  endtask

  task automatic backpressure_test();
    int base;
    int n;
    base = done_cnt;
    n = 0;
    bp_mode = 0;
    repeat (2) @(posedge clk);
    for (int i = 0; i < 4; i++) begin
      store_on_port(0, mem_addr_t'(8'h60 + i), mem_data_t'(32'h6000_0000 + i), req_tag_t'(i % 2));
    end
    // Fifth address finds the queue full
    @(posedge clk);
    st_addr_valid[0] <= 1'b1;
    st_addr[0]       <= {2'd0, 8'h64};
    @(negedge clk);
    check_value("address ready when full", 32'(st_addr_ready[0]), 32'd0);
    check_value("data ready when full", 32'(st_data_ready[0]), 32'd0);
    check_value("beats while stalled", 32'(done_cnt), 32'(base));
    bp_mode = 1;
    while (!st_addr_ready[0] && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!st_addr_ready[0]) report_timeout("store address ready after stall");
    @(posedge clk);
    st_addr_valid[0] <= 1'b0;
    ref_mem[8'h64] = 32'h6000_0064;
    send_data(0, 2'd0, 32'h6000_0064);
    wait_done(base + 5);
    for (int i = 0; i < 5; i++) begin
      load_one(i % 2, mem_addr_t'(8'h60 + i), 2'd1);
    end
  endtask

  task automatic error_tag_test();
    apply_reset();
    @(negedge clk);
    check_value("error after reset", 32'(error_valid), 32'd0);
    check_value("store done after reset", 32'(st_done_valid), 32'd0);
    @(posedge clk);
    ld_req_valid[0] <= 1'b1;
    ld_req[0]       <= {2'd3, 8'h10};
    wait_error(4);
    check_value("tag range code", 32'(error_code), 32'(`EXT_MEM_ERR_TAG_OOB));
    @(posedge clk);
    ld_req_valid[0] <= 1'b0;
    send_addr(1, 2'd0, 8'h70);
    repeat (`EXT_MEM_DL_TIMEOUT + 8) @(posedge clk);
    check_value("error held", 32'(error_valid), 32'd1);
    check_value("code held", 32'(error_code), 32'(`EXT_MEM_ERR_TAG_OOB));
  endtask

  task automatic deadlock_test();
    apply_reset();
    @(negedge clk);
    check_value("error after second reset", 32'(error_valid), 32'd0);
    send_addr(1, 2'd1, 8'h71);
    wait_error(`EXT_MEM_DL_TIMEOUT + 8);
    check_value("deadlock code", 32'(error_code), 32'(`EXT_MEM_ERR_ST_DEADLOCK));
  endtask

  initial begin
    seed          = 87926;
    mismatches    = 0;
    timeouts      = 0;
    bp_mode       = 1;
    rst_n         = 1'b0;
    ld_req_valid  = '0;
    ld_req        = '0;
    ld_rsp_ready  = '1;
    ld_done_ready = 1'b1;
    st_addr_valid = '0;
    st_addr       = '0;
    st_data_valid = '0;
    st_data       = '0;
    apply_reset();
    build_table();
    run_table();
    pair_order_test();
    concurrent_test();
    backpressure_test();
    error_tag_test();
    deadlock_test();
    $display("Checks complete: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: ext_mem_top.sv
// Top of the external memory model; connects load path, store queues, arbiter and errors
`timescale 1ns/100ps
`include "ext_mem_config.svh"

module ext_mem_top
  import ext_mem_pkg::*;
(
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic     [`EXT_MEM_LD_PORTS-1:0]      ld_req_valid,
  input  ld_req_t  [`EXT_MEM_LD_PORTS-1:0]      ld_req,
  output logic     [`EXT_MEM_LD_PORTS-1:0]      ld_req_ready,
  output logic     [`EXT_MEM_LD_PORTS-1:0]      ld_rsp_valid,
  output mem_rsp_t [`EXT_MEM_LD_PORTS-1:0]      ld_rsp,
  input  logic     [`EXT_MEM_LD_PORTS-1:0]      ld_rsp_ready,
  output logic                                  ld_done_valid,
  output mem_rsp_t                              ld_done,
  input  logic                                  ld_done_ready,
  input  logic     [`EXT_MEM_ST_PORTS-1:0]      st_addr_valid,
  input  st_addr_t [`EXT_MEM_ST_PORTS-1:0]      st_addr,
  output logic     [`EXT_MEM_ST_PORTS-1:0]      st_addr_ready,
  input  logic     [`EXT_MEM_ST_PORTS-1:0]      st_data_valid,
  input  st_data_t [`EXT_MEM_ST_PORTS-1:0]      st_data,
  output logic     [`EXT_MEM_ST_PORTS-1:0]      st_data_ready,
  output logic                                  st_done_valid,
  output mem_rsp_t                              st_done,
  input  logic                                  st_done_ready,
  output logic                                  error_valid,
  output err_code_t                             error_code
);

  logic     [`EXT_MEM_ST_PORTS-1:0] pair_req;
  logic     [`EXT_MEM_ST_PORTS-1:0] grant;
  logic     [`EXT_MEM_ST_PORTS-1:0] dl_hit;
  mem_wr_t  [`EXT_MEM_ST_PORTS-1:0] head_wr;
  req_tag_t [`EXT_MEM_ST_PORTS-1:0] head_tag;
  mem_wr_t                          mem_wr;
  logic                             mem_we;

  // ----------------------------------------------------------
  // Storage and load path
  // ----------------------------------------------------------
  ext_mem_array u_array (
    .clk          (clk),
    .mem_we       (mem_we),
    .mem_wr       (mem_wr),
    .ld_req_valid (ld_req_valid),
    .ld_req       (ld_req),
    .ld_req_ready (ld_req_ready),
    .ld_rsp_valid (ld_rsp_valid),
    .ld_rsp       (ld_rsp),
    .ld_rsp_ready (ld_rsp_ready),
    .ld_done_valid(ld_done_valid),
    .ld_done      (ld_done),
    .ld_done_ready(ld_done_ready)
  );

  // ----------------------------------------------------------
  // Store path, one queue pair per port
  // ----------------------------------------------------------
  for (genvar p = 0; p < `EXT_MEM_ST_PORTS; p++) begin : g_st
    store_pair_queue u_queue (
      .clk       (clk),
      .rst_n     (rst_n),
      .addr_valid(st_addr_valid[p]),
      .addr      (st_addr[p]),
      .addr_ready(st_addr_ready[p]),
      .data_valid(st_data_valid[p]),
      .data      (st_data[p]),
      .data_ready(st_data_ready[p]),
      .pair_req  (pair_req[p]),
      .grant     (grant[p]),
      .head_wr   (head_wr[p]),
      .head_tag  (head_tag[p]),
      .dl_hit    (dl_hit[p])
    );
  end

  store_write_arbiter u_arb (
    .clk          (clk),
    .rst_n        (rst_n),
    .pair_req     (pair_req),
    .head_wr      (head_wr),
    .head_tag     (head_tag),
    .grant        (grant),
    .mem_wr       (mem_wr),
    .mem_we       (mem_we),
    .st_done_valid(st_done_valid),
    .st_done      (st_done),
    .st_done_ready(st_done_ready)
  );

  // Watches raw inputs, so a bad tag is flagged even if never accepted
  mem_error_monitor u_err (
    .clk          (clk),
    .rst_n        (rst_n),
    .ld_req_valid (ld_req_valid),
    .ld_req       (ld_req),
    .st_addr_valid(st_addr_valid),
    .st_addr      (st_addr),
    .st_data_valid(st_data_valid),
    .st_data      (st_data),
    .dl_hit       (dl_hit),
    .error_valid  (error_valid),
    .error_code   (error_code)
  );

endmodule

// File: mem_error_monitor.sv
// Tag range checks and store deadlock reporting, holding the first error until reset
`timescale 1ns/100ps
`include "ext_mem_config.svh"

module mem_error_monitor
  import ext_mem_pkg::*;
(
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic     [`EXT_MEM_LD_PORTS-1:0]      ld_req_valid,
  input  ld_req_t  [`EXT_MEM_LD_PORTS-1:0]      ld_req,
  input  logic     [`EXT_MEM_ST_PORTS-1:0]      st_addr_valid,
  input  st_addr_t [`EXT_MEM_ST_PORTS-1:0]      st_addr,
  input  logic     [`EXT_MEM_ST_PORTS-1:0]      st_data_valid,
  input  st_data_t [`EXT_MEM_ST_PORTS-1:0]      st_data,
  input  logic     [`EXT_MEM_ST_PORTS-1:0]      dl_hit,
  output logic                                  error_valid,
  output err_code_t                             error_code
);

  logic      tag_oob;
  logic      err_detect;
  err_code_t err_code_next;

  // Any valid tag at or past its own port count
  always_comb begin
    tag_oob = 1'b0;
    for (int i = 0; i < `EXT_MEM_LD_PORTS; i++) begin
      if (ld_req_valid[i] && int'(ld_req[i].tag) >= `EXT_MEM_LD_PORTS) begin
        tag_oob = 1'b1;
      end
    end
    for (int i = 0; i < `EXT_MEM_ST_PORTS; i++) begin
      if (st_addr_valid[i] && int'(st_addr[i].tag) >= `EXT_MEM_ST_PORTS) begin
        tag_oob = 1'b1;
      end
      if (st_data_valid[i] && int'(st_data[i].tag) >= `EXT_MEM_ST_PORTS) begin
        tag_oob = 1'b1;
      end
    end
  end

  // Tag range wins over deadlock
  assign err_detect    = tag_oob || (|dl_hit);
  assign err_code_next = tag_oob ? `EXT_MEM_ERR_TAG_OOB : `EXT_MEM_ERR_ST_DEADLOCK;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      error_valid <= 1'b0;
      error_code  <= '0;
    end else if (!error_valid && err_detect) begin
      error_valid <= 1'b1;
      error_code  <= err_code_next;
    end
  end

  a_error_sticky : assert property (@(posedge clk) disable iff (!rst_n)
    error_valid |=> error_valid && $stable(error_code));

endmodule

// File: ext_mem_array.sv
// Word array with clocked writes and same-cycle load responses and load-done merge
`timescale 1ns/100ps
`include "ext_mem_config.svh"

module ext_mem_array
  import ext_mem_pkg::*;
(
  input  logic                                  clk,
  input  logic                                  mem_we,
  input  mem_wr_t                               mem_wr,
  input  logic     [`EXT_MEM_LD_PORTS-1:0]      ld_req_valid,
  input  ld_req_t  [`EXT_MEM_LD_PORTS-1:0]      ld_req,
  output logic     [`EXT_MEM_LD_PORTS-1:0]      ld_req_ready,
  output logic     [`EXT_MEM_LD_PORTS-1:0]      ld_rsp_valid,
  output mem_rsp_t [`EXT_MEM_LD_PORTS-1:0]      ld_rsp,
  input  logic     [`EXT_MEM_LD_PORTS-1:0]      ld_rsp_ready,
  output logic                                  ld_done_valid,
  output mem_rsp_t                              ld_done,
  input  logic                                  ld_done_ready
);

  localparam int N = `EXT_MEM_LD_PORTS;

  mem_data_t mem [`EXT_MEM_DEPTH];

  // ----------------------------------------------------------
  // Write port
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem[mem_wr.addr] <= mem_wr.data;
    end
  end

  // ----------------------------------------------------------
  // Load ports, zero latency
  // ----------------------------------------------------------
  always_comb begin
    for (int i = 0; i < N; i++) begin
      ld_rsp_valid[i] = ld_req_valid[i];
      ld_rsp[i].tag   = ld_req[i].tag;
      ld_rsp[i].data  = mem[ld_req[i].addr];
      // Both the data and the done beat must be taken
      ld_req_ready[i] = ld_rsp_ready[i] && ld_done_ready;
    end
  end

  // Load done carries the tag of the highest active port
  always_comb begin
    ld_done_valid = 1'b0;
    ld_done       = '0;
    for (int i = 0; i < N; i++) begin
      if (ld_req_valid[i]) begin
        ld_done_valid = 1'b1;
        ld_done.tag   = ld_req[i].tag;
      end
    end
  end

endmodule

// File: store_write_arbiter.sv
// Round-robin sharing of the single memory write port among the store queues
`timescale 1ns/100ps
`include "ext_mem_config.svh"

module store_write_arbiter
  import ext_mem_pkg::*;
(
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic     [`EXT_MEM_ST_PORTS-1:0]       pair_req,
  input  mem_wr_t  [`EXT_MEM_ST_PORTS-1:0]       head_wr,
  input  req_tag_t [`EXT_MEM_ST_PORTS-1:0]       head_tag,
  output logic     [`EXT_MEM_ST_PORTS-1:0]       grant,
  output mem_wr_t                                mem_wr,
  output logic                                   mem_we,
  output logic                                   st_done_valid,
  output mem_rsp_t                               st_done,
  input  logic                                   st_done_ready
);

  localparam int N     = `EXT_MEM_ST_PORTS;
  localparam int IDX_W = $clog2(N);

  logic [IDX_W-1:0] rr_ptr;
  logic [IDX_W-1:0] sel_idx;
  logic [N-1:0]     sel;

  // First requester at or after the pointer, wrapping around
  always_comb begin
    int   idx;
    logic found;
    idx     = 0;
    found   = 1'b0;
    sel     = '0;
    sel_idx = '0;
    for (int k = 0; k < N; k++) begin
      idx = (int'(rr_ptr) + k) % N;
      if (!found && pair_req[idx]) begin
        found        = 1'b1;
        sel[idx]     = 1'b1;
        sel_idx      = IDX_W'(idx);
      end
    end
  end

  // Offer is visible regardless of ready, the pop waits for it
  assign grant         = sel & {N{st_done_ready}};
  assign mem_we        = |grant;
  assign mem_wr        = head_wr[sel_idx];
  assign st_done_valid = |pair_req;
  assign st_done.tag   = head_tag[sel_idx];
  assign st_done.data  = '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rr_ptr <= '0;
    end else if (|grant) begin
      rr_ptr <= (int'(sel_idx) == N - 1) ? '0 : sel_idx + 1'b1;
    end
  end

  a_grant_onehot : assert property (@(posedge clk) disable iff (!rst_n) $onehot0(grant));

endmodule

// File: store_pair_queue.sv
// Address and data queues of one store port, pairing them into write requests
`timescale 1ns/100ps
`include "ext_mem_config.svh"

module store_pair_queue
  import ext_mem_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     addr_valid,
  input  st_addr_t addr,
  output logic     addr_ready,
  input  logic     data_valid,
  input  st_data_t data,
  output logic     data_ready,
  output logic     pair_req,
  input  logic     grant,
  output mem_wr_t  head_wr,
  output req_tag_t head_tag,
  output logic     dl_hit
);

  localparam int DEPTH = `EXT_MEM_LSQ_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = PTR_W + 1;
  localparam logic [`EXT_MEM_DL_CNT_W-1:0] DL_MAX = `EXT_MEM_DL_CNT_W'(`EXT_MEM_DL_TIMEOUT);

  st_addr_t             addr_mem [DEPTH];
  mem_data_t            data_mem [DEPTH];
  logic [PTR_W-1:0]     addr_wr_ptr;
  logic [PTR_W-1:0]     addr_rd_ptr;
  logic [PTR_W-1:0]     data_wr_ptr;
  logic [PTR_W-1:0]     data_rd_ptr;
  logic [CNT_W-1:0]     addr_cnt;
  logic [CNT_W-1:0]     data_cnt;
  logic                 addr_enq;
  logic                 data_enq;
  logic                 addr_empty;
  logic                 data_empty;
  logic [`EXT_MEM_DL_CNT_W-1:0] dl_cnt;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign addr_empty = (addr_cnt == '0);
  assign data_empty = (data_cnt == '0);
  assign addr_ready = (addr_cnt != CNT_W'(DEPTH));
  assign data_ready = (data_cnt != CNT_W'(DEPTH));
  assign addr_enq   = addr_valid && addr_ready;
  assign data_enq   = data_valid && data_ready;

  // ----------------------------------------------------------
  // Queue storage, payload only
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (addr_enq) begin
      addr_mem[addr_wr_ptr] <= addr;
    end
    // Data tag is not kept past the input
    if (data_enq) begin
      data_mem[data_wr_ptr] <= data.data;
    end
  end

  // Pointers and counts; a grant pops both heads together
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_wr_ptr <= '0;
      addr_rd_ptr <= '0;
      data_wr_ptr <= '0;
      data_rd_ptr <= '0;
      addr_cnt    <= '0;
      data_cnt    <= '0;
    end else begin
      if (addr_enq) begin
        addr_wr_ptr <= ptr_inc(addr_wr_ptr);
      end
      if (data_enq) begin
        data_wr_ptr <= ptr_inc(data_wr_ptr);
      end
      if (grant) begin
        addr_rd_ptr <= ptr_inc(addr_rd_ptr);
        data_rd_ptr <= ptr_inc(data_rd_ptr);
      end
      addr_cnt <= addr_cnt + CNT_W'(addr_enq) - CNT_W'(grant);
      data_cnt <= data_cnt + CNT_W'(data_enq) - CNT_W'(grant);
    end
  end

  assign pair_req     = !addr_empty && !data_empty;
  assign head_wr.addr = addr_mem[addr_rd_ptr].addr;
  assign head_wr.data = data_mem[data_rd_ptr];
  assign head_tag     = addr_mem[addr_rd_ptr].tag;

  // ----------------------------------------------------------
  // Deadlock watch
  // ----------------------------------------------------------

  // Counts while exactly one side holds entries, sticks at the limit
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dl_cnt <= '0;
    end else if (addr_empty == data_empty) begin
      dl_cnt <= '0;
    end else if (dl_cnt != DL_MAX) begin
      dl_cnt <= dl_cnt + 1'b1;
    end
  end

  assign dl_hit = (dl_cnt == DL_MAX);

  a_grant_needs_req : assert property (@(posedge clk) disable iff (!rst_n)
    grant |-> pair_req);

  a_cnt_in_range : assert property (@(posedge clk) disable iff (!rst_n)
    (addr_cnt <= CNT_W'(DEPTH)) && (data_cnt <= CNT_W'(DEPTH)));

endmodule

// File: ext_mem_pkg.sv
// Vector and struct types for the external memory requests, responses and writes
`include "ext_mem_config.svh"

package ext_mem_pkg;

  // ----------------------------------------------------------
  // Plain vector types
  // ----------------------------------------------------------
  typedef logic [`EXT_MEM_DATA_W-1:0] mem_data_t;
  typedef logic [`EXT_MEM_ADDR_W-1:0] mem_addr_t;
  typedef logic [`EXT_MEM_TAG_W-1:0] req_tag_t;
  typedef logic [15:0] err_code_t;

  // ----------------------------------------------------------
  // Stream payloads
  // ----------------------------------------------------------

  // Load request, tag in the upper bits
  typedef struct packed {
    req_tag_t  tag;
    mem_addr_t addr;
  } ld_req_t;

  // Store address half of a store
  typedef struct packed {
    req_tag_t  tag;
    mem_addr_t addr;
  } st_addr_t;

  // Store data half of a store
  typedef struct packed {
    req_tag_t  tag;
    mem_data_t data;
  } st_data_t;

  // Load data, load done and store done; data is zero on the done streams
  typedef struct packed {
    req_tag_t  tag;
    mem_data_t data;
  } mem_rsp_t;

  // One write into the word array
  typedef struct packed {
    mem_addr_t addr;
    mem_data_t data;
  } mem_wr_t;

endpackage

// File: ext_mem_config.svh
// Shared widths, depths, port counts and error codes for the external memory model
`ifndef EXT_MEM_CONFIG_SVH
`define EXT_MEM_CONFIG_SVH

// ----------------------------------------------------------
// Data path widths
// ----------------------------------------------------------
`define EXT_MEM_DATA_W 32
`define EXT_MEM_ADDR_W 8
`define EXT_MEM_DEPTH 256
`define EXT_MEM_TAG_W 2

// ----------------------------------------------------------
// Port counts and store queue sizing
// ----------------------------------------------------------
`define EXT_MEM_LD_PORTS 2
`define EXT_MEM_ST_PORTS 2
`define EXT_MEM_LSQ_DEPTH 4

// One-sided wait before a store port is declared stuck
`define EXT_MEM_DL_TIMEOUT 32
`define EXT_MEM_DL_CNT_W 6

// ----------------------------------------------------------
// Runtime error codes
// ----------------------------------------------------------
`define EXT_MEM_ERR_TAG_OOB 16'd1
`define EXT_MEM_ERR_ST_DEADLOCK 16'd2

`endif
